// File: fire_expand_defines.svh
// Global sizes, quantization and register map of the fire expand 1x1 engine
`ifndef FIRE_EXPAND_DEFINES_SVH
`define FIRE_EXPAND_DEFINES_SVH

// Input channels, also the beats per pixel
`define EXP_CHIN 4
// Output channels, one MAC lane each
`define EXP_CHOUT 4

// Pixel, weight and output lane width
`define EXP_DW 16
// Accumulator and bias width
`define EXP_AW 32
// Fraction bits dropped on requantization
`define EXP_QSHIFT 14

// Largest layer size in pixels
`define EXP_MAXPIX 4096

// Wishbone word addresses
`define EXP_REG_CTRL 2'd0
`define EXP_REG_NPIX 2'd1
`define EXP_REG_STATUS 2'd2

`endif

// File: fire_expand_data_pkg.sv
// Datapath vector types for pixels, weights, accumulators and counters
`include "fire_expand_defines.svh"

package fire_expand_data_pkg;

	// One feature-map value, input or output
	typedef logic signed [`EXP_DW-1:0] pix_t;

	// One kernel weight, fraction in the low QSHIFT bits
	typedef logic signed [`EXP_DW-1:0] weight_t;

	// Accumulator, same scale as the bias
	typedef logic signed [`EXP_AW-1:0] acc_t;

	// ROM address, the input channel of the beat
	typedef logic [$clog2(`EXP_CHIN)-1:0] chan_idx_t;

	// Pixel counter
	// One extra bit so MAXPIX itself fits
	typedef logic [$clog2(`EXP_MAXPIX):0] pix_cnt_t;

endpackage

// File: fire_expand_ctrl_pkg.sv
// Control types shared by the register slave and the sequencer

package fire_expand_ctrl_pkg;

	// Layer select
	// 0 picks fire2, 1 picks fire3
	typedef logic layer_t;

	// Sequencer states
	typedef enum logic [1:0] {
		// Waiting for start
		IDLE,
		// Accepting pixel beats
		RUN,
		// Last pixel still in the MAC pipeline
		DRAIN,
		// Layer finished, done shown in STATUS
		DONE
	} ctrl_state_t;

endpackage

// File: expand_ctrl.sv
// Sequencer that counts beats and pixels, feeds the MAC pipeline and flags layer end
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module expand_ctrl import fire_expand_data_pkg::*, fire_expand_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst_gen,
	input  logic      start_i,
	input  layer_t    layer_i,
	input  pix_cnt_t  npix_i,
	input  pix_t      pix_i,
	input  logic      pix_valid_i,
	output logic      pix_ready_o,
	output chan_idx_t rom_chan_o,
	output layer_t    rom_layer_o,
	output pix_t      mac_pix_o,
	output logic      mac_en_o,
	output logic      mac_first_o,
	output logic      mac_last_o,
	output logic      busy_o,
	output logic      done_o
);

	// Cycles spent in DRAIN, matches the output latency
	localparam int DRAIN_CYC = 3;

	ctrl_state_t state;
	chan_idx_t   chan_cnt;
	pix_cnt_t    pix_cnt;
	pix_cnt_t    npix_q;
	layer_t      layer_q;
	logic [1:0]  drain_cnt;
	logic        beat;
	logic        last_beat;
	logic        last_q;

	// Ready until all pixels of the layer are taken
	assign pix_ready_o = (state == RUN) && (pix_cnt != npix_q);
	assign beat        = pix_valid_i && pix_ready_o;
	assign last_beat   = beat && (chan_cnt == chan_idx_t'(`EXP_CHIN - 1));

	// ROM follows the channel of the beat on the bus
	assign rom_chan_o  = chan_cnt;
	assign rom_layer_o = layer_q;

	assign busy_o = (state == RUN) || (state == DRAIN);
	assign done_o = (state == DONE);

	////////////////////////////////////////////////////////////
	// State and counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			state     <= IDLE;
			chan_cnt  <= '0;
			pix_cnt   <= '0;
			npix_q    <= '0;
			layer_q   <= '0;
			drain_cnt <= '0;
		end else begin
			case (state)
				IDLE, DONE: begin
					// Config is frozen for the whole layer
					if (start_i) begin
						state    <= RUN;
						layer_q  <= layer_i;
						npix_q   <= npix_i;
						chan_cnt <= '0;
						pix_cnt  <= '0;
					end
				end
				RUN: begin
					if (last_beat)
						chan_cnt <= '0;
					else if (beat)
						chan_cnt <= chan_cnt + 1'b1;
					if (last_beat)
						pix_cnt <= pix_cnt + 1'b1;
					// Final beat taken, or empty layer
					if ((last_beat && (pix_cnt == npix_q - 1'b1)) || (pix_cnt == npix_q)) begin
						state     <= DRAIN;
						drain_cnt <= '0;
					end
				end
				DRAIN: begin
					if (drain_cnt == 2'(DRAIN_CYC - 1))
						state <= DONE;
					else
						drain_cnt <= drain_cnt + 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// MAC stage, one cycle behind acceptance
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			mac_en_o    <= 1'b0;
			mac_first_o <= 1'b0;
			last_q      <= 1'b0;
			mac_last_o  <= 1'b0;
		end else begin
			mac_en_o    <= beat;
			mac_first_o <= beat && (chan_cnt == '0);
			last_q      <= last_beat;
			// Extra stage so the sums are settled at capture
			mac_last_o  <= last_q;
		end
	end

	always_ff @(posedge clk) begin
		if (beat)
			mac_pix_o <= pix_i;
	end

	// No ready outside RUN, also covers DRAIN and DONE
	a_ready_run: assert property (@(posedge clk) disable iff (rst_gen)
		pix_ready_o |-> (state == RUN));

	// Last capture strobe lands before DRAIN runs out
	a_last_busy: assert property (@(posedge clk) disable iff (rst_gen)
		mac_last_o |-> busy_o);

endmodule

// File: expand_weight_rom.sv
// Constant weight and bias tables of the fire2 and fire3 expand layers
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module expand_weight_rom import fire_expand_data_pkg::*, fire_expand_ctrl_pkg::*; (
	input  layer_t                   layer_i,
	input  chan_idx_t                chan_i,
	output weight_t [`EXP_CHOUT-1:0] weights_o,
	output acc_t    [`EXP_CHOUT-1:0] bias_o
);

	// Weights in Q14, 16384 is 1.0
	// Each row lists lane 3 down to lane 0
	always_comb begin
		case ({layer_i, chan_i})
			// fire2
			3'b0_00: weights_o = {16'sd16384, 16'sd2048, -16'sd4096, 16'sd8192};
			3'b0_01: weights_o = {16'sd1024, -16'sd8192, 16'sd8192, 16'sd4096};
			3'b0_10: weights_o = {-16'sd4096, 16'sd12288, 16'sd4096, -16'sd2048};
			3'b0_11: weights_o = {16'sd8192, 16'sd4096, -16'sd1024, 16'sd1024};
			// fire3
			3'b1_00: weights_o = {-16'sd2048, 16'sd4096, 16'sd2048, -16'sd8192};
			3'b1_01: weights_o = {16'sd8192, 16'sd1024, -16'sd4096, 16'sd12288};
			3'b1_10: weights_o = {16'sd4096, -16'sd2048, 16'sd16384, 16'sd2048};
			3'b1_11: weights_o = {-16'sd1024, 16'sd8192, 16'sd1024, -16'sd4096};
			default: weights_o = '0;
		endcase
	end

	// Bias on the accumulator scale
	// Only the layer matters here
	always_comb begin
		case (layer_i)
			1'b0:    bias_o = {32'sd0, 32'sd16384, -32'sd32768, 32'sd65536};
			1'b1:    bias_o = {32'sd49152, 32'sd0, 32'sd131072, -32'sd16384};
			default: bias_o = '0;
		endcase
	end

endmodule

// File: mac_array.sv
// Bank of multiply-accumulate lanes, one per output channel
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module mac_array import fire_expand_data_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_gen,
	input  logic                     en_i,
	input  logic                     first_i,
	input  pix_t                     pix_i,
	input  weight_t [`EXP_CHOUT-1:0] weights_i,
	output acc_t    [`EXP_CHOUT-1:0] acc_o
);

	weight_t [`EXP_CHOUT-1:0] weights_q;
	acc_t    [`EXP_CHOUT-1:0] prod;

	// Weights of the accepted beat
	// Lines up with the pixel registered by the sequencer
	always_ff @(posedge clk) begin
		weights_q <= weights_i;
	end

	// Full 16x16 signed product fits the accumulator
	always_comb begin
		for (int i = 0; i < `EXP_CHOUT; i++)
			prod[i] = acc_t'(pix_i) * acc_t'(weights_q[i]);
	end

	////////////////////////////////////////////////////////////
	// Accumulate lanes
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst_gen) begin
			acc_o <= '0;
		end else if (en_i) begin
			for (int i = 0; i < `EXP_CHOUT; i++) begin
				// Load on channel 0 so pixels run back to back
				if (first_i)
					acc_o[i] <= prod[i];
				else
					acc_o[i] <= acc_o[i] + prod[i];
			end
		end
	end

	a_first_en: assert property (@(posedge clk) disable iff (rst_gen)
		first_i |-> en_i);

endmodule

// File: bias_relu_quant.sv
// Bias add, ReLU and requantization of the MAC sums into the output vector
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module bias_relu_quant import fire_expand_data_pkg::*, fire_expand_ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_gen,
	input  logic                  capture_i,
	input  layer_t                layer_i,
	input  acc_t [`EXP_CHOUT-1:0] acc_i,
	input  acc_t [`EXP_CHOUT-1:0] bias_i,
	output pix_t [`EXP_CHOUT-1:0] ofm_o,
	output logic                  ofm_valid_o
);

	acc_t [`EXP_CHOUT-1:0] sum;

	always_comb begin
		for (int i = 0; i < `EXP_CHOUT; i++)
			sum[i] = acc_i[i] + bias_i[i];
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (capture_i) begin
			for (int i = 0; i < `EXP_CHOUT; i++) begin
				// ReLU
				if (sum[i][`EXP_AW-1])
					ofm_o[i] <= '0;
				// Keep 15 bits above the fraction, sign forced to 0
				else
					ofm_o[i] <= {1'b0, sum[i][`EXP_QSHIFT+`EXP_DW-2:`EXP_QSHIFT]};
			end
		end
	end

	// One pulse per pixel
	always_ff @(posedge clk) begin
		if (rst_gen)
			ofm_valid_o <= 1'b0;
		else
			ofm_valid_o <= capture_i;
	end

	// Bias must belong to the running layer
	a_layer_stable: assert property (@(posedge clk) disable iff (rst_gen)
		capture_i |-> $stable(layer_i));

endmodule

// File: wb_cfg_slave.sv
// Wishbone classic register slave for start, layer select, pixel count and status
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module wb_cfg_slave import fire_expand_data_pkg::*, fire_expand_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        rst_gen,
	input  logic        wb_cyc_i,
	input  logic        wb_stb_i,
	input  logic        wb_we_i,
	input  logic [1:0]  wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack_o,
	output logic        start_o,
	output layer_t      layer_o,
	output pix_cnt_t    npix_o,
	input  logic        busy_i,
	input  logic        done_i
);

	logic req;

	// New request, not yet acked
	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

	always_ff @(posedge clk) begin
		if (rst_gen) begin
			wb_ack_o <= 1'b0;
			start_o  <= 1'b0;
			layer_o  <= '0;
			npix_o   <= '0;
			wb_dat_o <= '0;
		end else begin
			wb_ack_o <= req;
			// Start lasts one cycle
			start_o  <= 1'b0;
			if (req && wb_we_i) begin
				case (wb_adr_i)
					`EXP_REG_CTRL: begin
						layer_o <= wb_dat_i[1];
						// Dropped while a layer runs
						start_o <= wb_dat_i[0] && !busy_i;
					end
					`EXP_REG_NPIX: npix_o <= wb_dat_i[$bits(pix_cnt_t)-1:0];
					default: ;
				endcase
			end
			if (req && !wb_we_i) begin
				case (wb_adr_i)
					`EXP_REG_CTRL:   wb_dat_o <= {30'd0, layer_o, 1'b0};
					`EXP_REG_NPIX:   wb_dat_o <= 32'(npix_o);
					`EXP_REG_STATUS: wb_dat_o <= {30'd0, done_i, busy_i};
					default:         wb_dat_o <= '0;
				endcase
			end
		end
	end

	// Master keeps the strobe up until it sees the ack
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst_gen)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

// File: fire_expand_top.sv
// Fire expand 1x1 engine with Wishbone config, pixel stream in and output vector
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module fire_expand_top import fire_expand_data_pkg::*, fire_expand_ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_gen,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [1:0]            wb_adr_i,
	input  logic [31:0]           wb_dat_i,
	output logic [31:0]           wb_dat_o,
	output logic                  wb_ack_o,
	input  pix_t                  pix_i,
	input  logic                  pix_valid_i,
	output logic                  pix_ready_o,
	output pix_t [`EXP_CHOUT-1:0] ofm_o,
	output logic                  ofm_valid_o
);

	// Config and status
	logic     start;
	layer_t   layer;
	pix_cnt_t npix;
	logic     busy;
	logic     done;

	// ROM lookup
	chan_idx_t                rom_chan;
	layer_t                   rom_layer;
	weight_t [`EXP_CHOUT-1:0] weights;
	acc_t    [`EXP_CHOUT-1:0] bias;

	// MAC stage
	pix_t                  mac_pix;
	logic                  mac_en;
	logic                  mac_first;
	logic                  mac_last;
	acc_t [`EXP_CHOUT-1:0] acc;

	wb_cfg_slave u_wb_cfg_slave (
		.clk(clk), .rst_gen(rst_gen),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.start_o(start), .layer_o(layer), .npix_o(npix), .busy_i(busy), .done_i(done)
	);

	expand_ctrl u_expand_ctrl (
		.clk(clk), .rst_gen(rst_gen), .start_i(start), .layer_i(layer), .npix_i(npix),
		.pix_i(pix_i), .pix_valid_i(pix_valid_i), .pix_ready_o(pix_ready_o),
		.rom_chan_o(rom_chan), .rom_layer_o(rom_layer), .mac_pix_o(mac_pix),
		.mac_en_o(mac_en), .mac_first_o(mac_first), .mac_last_o(mac_last),
		.busy_o(busy), .done_o(done)
	);

	expand_weight_rom u_expand_weight_rom (
		.layer_i(rom_layer), .chan_i(rom_chan), .weights_o(weights), .bias_o(bias)
	);

	mac_array u_mac_array (
		.clk(clk), .rst_gen(rst_gen), .en_i(mac_en), .first_i(mac_first),
		.pix_i(mac_pix), .weights_i(weights), .acc_o(acc)
	);

	bias_relu_quant u_bias_relu_quant (
		.clk(clk), .rst_gen(rst_gen), .capture_i(mac_last), .layer_i(rom_layer),
		.acc_i(acc), .bias_i(bias), .ofm_o(ofm_o), .ofm_valid_o(ofm_valid_o)
	);

endmodule

// File: tb_fire_expand_checker.sv
// Output checker, compares every output vector and its latency with the data file
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module tb_fire_expand_checker import fire_expand_data_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_gen,
	input  logic                  pix_valid_i,
	input  logic                  pix_ready_i,
	input  pix_t [`EXP_CHOUT-1:0] ofm_i,
	input  logic                  ofm_valid_i,
	input  logic                  end_i,
	output int                    err_cnt_o,
	output int                    out_cnt_o
);

	pix_t [`EXP_CHOUT-1:0] exp_q[$];
	// Cycle of each pixel's last accepted beat
	int                    last_t[$];
	int                    cycle;
	int                    chan;
	logic                  end_seen;

	initial begin
		int          fd;
		int          r;
		int          lay;
		int          np;
		string       line;
		logic [15:0] v[8];
		pix_t [`EXP_CHOUT-1:0] vec;
		err_cnt_o = 0;
		out_cnt_o = 0;
		cycle     = 0;
		chan      = 0;
		end_seen  = 1'b0;
		fd = $fopen("fire_expand_input.txt", "r");
		if (fd == 0) begin
			$display("Checker cannot open fire_expand_input.txt");
			err_cnt_o++;
		end else begin
			r = $fgets(line, fd);
			r = $fgets(line, fd);
			while ($fscanf(fd, "%h %h", lay, np) == 2) begin
				for (int p = 0; p < np; p++) begin
					r = $fscanf(fd, "%h %h %h %h %h %h %h %h",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
					// Expected lanes follow the four inputs
					for (int i = 0; i < `EXP_CHOUT; i++)
						vec[i] = pix_t'(v[`EXP_CHIN + i]);
					exp_q.push_back(vec);
				end
			end
			$fclose(fd);
		end
	end

	////////////////////////////////////////////////////////////
	// Compare on every valid
	////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		pix_t [`EXP_CHOUT-1:0] exp;
		int                    t;
		cycle++;
		if (!rst_gen && pix_valid_i && pix_ready_i) begin
			if (chan == `EXP_CHIN - 1) begin
				last_t.push_back(cycle);
				chan = 0;
			end else
				chan++;
		end
		if (!rst_gen && ofm_valid_i) begin
			if (exp_q.size() == 0) begin
				$display("Output vector %0d arrived with no expected vector left", out_cnt_o);
				err_cnt_o++;
			end else begin
				exp = exp_q.pop_front();
				for (int i = 0; i < `EXP_CHOUT; i++)
					if (ofm_i[i] !== exp[i]) begin
						$display("** Error ofm_o[%0d] vector %0d: expected %h got %h",
							i, out_cnt_o, exp[i], ofm_i[i]);
						err_cnt_o++;
					end
			end
			if (last_t.size() == 0) begin
				$display("Output vector %0d came before its pixel was complete", out_cnt_o);
				err_cnt_o++;
			end else begin
				t = last_t.pop_front();
				if (cycle - t != 3) begin
					$display("Output vector %0d came %0d cycles after its last beat, not 3",
						out_cnt_o, cycle - t);
					err_cnt_o++;
				end
			end
			out_cnt_o++;
		end
		if (end_i && !end_seen) begin
			end_seen = 1'b1;
			if (exp_q.size() != 0) begin
				$display("%0d expected output vectors never arrived", exp_q.size());
				err_cnt_o++;
			end
		end
	end

endmodule

// File: tb_fire_expand.sv
// Testbench top for the fire expand engine, Wishbone config and pixel stream from the data file
`timescale 1ns/1ps
`include "fire_expand_defines.svh"

module tb_fire_expand import fire_expand_data_pkg::*; ();

	localparam int CLK_HALF = 2;

	logic                  clk;
	logic                  rst_gen;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic                  wb_we_i;
	logic [1:0]            wb_adr_i;
	logic [31:0]           wb_dat_i;
	logic [31:0]           wb_dat_o;
	logic                  wb_ack_o;
	pix_t                  pix_i;
	logic                  pix_valid_i;
	logic                  pix_ready_o;
	pix_t [`EXP_CHOUT-1:0] ofm_o;
	logic                  ofm_valid_o;

	int   seed;
	int   errors;
	int   chk_errors;
	int   out_cnt;
	logic chk_end;
	int   wd_cycles;
	logic wd_armed;

	// Tests as read from the data file
	int   test_layer[$];
	int   test_npix[$];
	pix_t beats[$];

	always #CLK_HALF clk = ~clk;

	fire_expand_top u_dut (
		.clk(clk), .rst_gen(rst_gen),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.pix_i(pix_i), .pix_valid_i(pix_valid_i), .pix_ready_o(pix_ready_o),
		.ofm_o(ofm_o), .ofm_valid_o(ofm_valid_o)
	);

	tb_fire_expand_checker u_chk (
		.clk(clk), .rst_gen(rst_gen), .pix_valid_i(pix_valid_i), .pix_ready_i(pix_ready_o),
		.ofm_i(ofm_o), .ofm_valid_i(ofm_valid_o), .end_i(chk_end),
		.err_cnt_o(chk_errors), .out_cnt_o(out_cnt)
	);

	////////////////////////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////////////////////////
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_dat_i <= wdat;
		@(posedge clk);
		// Ack comes one cycle after the request is seen
		while (!wb_ack_o && waited < 16) begin
			@(posedge clk);
			waited++;
		end
		if (!wb_ack_o) begin
			$display("Wishbone access to address %0d got no ack", adr);
			errors++;
		end
		rdat = wb_dat_o;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
		@(posedge clk);
		if (wb_ack_o) begin
			$display("Wishbone access to address %0d got a second ack", adr);
			errors++;
		end
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		wb_access(1'b1, adr, wdat, unused);
	endtask

	task automatic check_reg(input logic [1:0] adr, input logic [31:0] exp, input string name);
		logic [31:0] got;
		wb_access(1'b0, adr, 32'd0, got);
		if (got !== exp) begin
			$display("** Error %s: expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	// One beat, with random idle cycles before it
	task automatic send_beat(input pix_t v);
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			if (($random(seed) & 3) == 0) begin
				pix_valid_i <= 1'b0;
				@(posedge clk);
			end else begin
				pix_valid_i <= 1'b1;
				pix_i       <= v;
				@(posedge clk);
				if (pix_ready_o)
					taken = 1'b1;
			end
		end
	endtask

	task automatic run_test(input int layer, input int npix, input int base, input int seen);
		logic [31:0] st;
		int          polls;
		wb_write(`EXP_REG_NPIX, 32'(npix));
		check_reg(`EXP_REG_NPIX, 32'(npix), "wb_dat_o NPIX");
		wb_write(`EXP_REG_CTRL, {30'd0, layer[0], 1'b1});
		check_reg(`EXP_REG_CTRL, {30'd0, layer[0], 1'b0}, "wb_dat_o CTRL");
		// Running, old done cleared
		check_reg(`EXP_REG_STATUS, 32'd1, "wb_dat_o STATUS");
		for (int i = 0; i < npix * `EXP_CHIN; i++) begin
			send_beat(beats[base + i]);
			// Restart attempt mid layer must be dropped
			if (i == `EXP_CHIN - 1) begin
				pix_valid_i <= 1'b0;
				wb_write(`EXP_REG_CTRL, {30'd0, layer[0], 1'b1});
			end
		end
		pix_valid_i <= 1'b0;
		polls = 0;
		st    = '0;
		while (!st[1] && polls < 64) begin
			wb_access(1'b0, `EXP_REG_STATUS, 32'd0, st);
			polls++;
		end
		if (!st[1]) begin
			$display("Layer %0d never reported done", layer);
			errors++;
		end
		check_reg(`EXP_REG_STATUS, 32'd2, "wb_dat_o STATUS");
		if (pix_ready_o !== 1'b0) begin
			$display("pix_ready_o still high after the layer ended");
			errors++;
		end
		if (out_cnt != seen + npix) begin
			$display("Layer gave %0d output vectors, expected %0d", out_cnt - seen, npix);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int             fd;
		int             r;
		int             lay;
		int             np;
		int             base;
		int             seen;
		string          line;
		logic [15:0]    v[8];
		seed        = 32'h304f_dc49;
		errors      = 0;
		clk         = 1'b0;
		rst_gen     = 1'b1;
		wb_cyc_i    = 1'b0;
		wb_stb_i    = 1'b0;
		wb_we_i     = 1'b0;
		wb_adr_i    = '0;
		wb_dat_i    = '0;
		pix_i       = '0;
		pix_valid_i = 1'b0;
		chk_end     = 1'b0;
		wd_armed    = 1'b0;
		wd_cycles   = 0;

		fd = $fopen("fire_expand_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open fire_expand_input.txt");
			errors++;
		end else begin
			// Two column description lines
			r = $fgets(line, fd);
			r = $fgets(line, fd);
			while ($fscanf(fd, "%h %h", lay, np) == 2) begin
				test_layer.push_back(lay);
				test_npix.push_back(np);
				for (int p = 0; p < np; p++) begin
					r = $fscanf(fd, "%h %h %h %h %h %h %h %h",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
					for (int c = 0; c < `EXP_CHIN; c++)
						beats.push_back(pix_t'(v[c]));
				end
			end
			$fclose(fd);
		end

		repeat (4) @(posedge clk);
		rst_gen <= 1'b0;
		@(posedge clk);
		if (pix_ready_o !== 1'b0 || ofm_valid_o !== 1'b0) begin
			$display("pix_ready_o or ofm_valid_o high after reset");
			errors++;
		end
		check_reg(`EXP_REG_STATUS, 32'd0, "wb_dat_o STATUS");

		// Gaps average one in four, plus Wishbone overhead per test
		wd_cycles = beats.size() * 8 + test_layer.size() * 200 + 100;
		wd_armed  = 1'b1;

		base = 0;
		seen = 0;
		for (int t = 0; t < test_layer.size(); t++) begin
			run_test(test_layer[t], test_npix[t], base, seen);
			base += test_npix[t] * `EXP_CHIN;
			seen += test_npix[t];
		end

		chk_end <= 1'b1;
		repeat (2) @(posedge clk);
		$display("Errors: testbench %0d, checker %0d", errors, chk_errors);
		if (errors == 0 && chk_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog
	initial begin
		wait (wd_armed);
		repeat (wd_cycles) @(posedge clk);
		$display("Watchdog expired before the last test finished");
		$display("tests failed");
		$finish;
	end

endmodule

// File: fire_expand_input.txt
# Test line: layer npix. Then one line per pixel, all hex:
# inputs ch0 ch1 ch2 ch3, then expected output lanes 0 1 2 3
0 4
0010 0020 0030 0040 0012 0012 0027 0026
ffe0 0050 0000 0010 0009 002d 0000 0000
00a0 ffd0 0060 ff90 0035 0000 0059 004d
0001 0000 0000 0000 0004 0000 0001 0001
1 4
0010 0020 0030 0040 0005 0036 0020 0019
ffe0 0050 0000 0010 0047 0000 0005 002e
00a0 ffd0 0060 ff90 0000 0081 0000 0000
0001 0000 0000 0000 0000 0008 0000 0002
0 6
00a0 ffd0 0060 ff90 0035 0000 0059 004d
0010 0020 0030 0040 0012 0012 0027 0026
0001 0000 0000 0000 0004 0000 0001 0001
ffe0 0050 0000 0010 0009 002d 0000 0000
0010 0020 0030 0040 0012 0012 0027 0026
00a0 ffd0 0060 ff90 0035 0000 0059 004d

// File: fire_expand.f
+incdir+.
fire_expand_data_pkg.sv
fire_expand_ctrl_pkg.sv
expand_ctrl.sv
expand_weight_rom.sv
mac_array.sv
bias_relu_quant.sv
wb_cfg_slave.sv
fire_expand_top.sv
tb_fire_expand_checker.sv
tb_fire_expand.sv

// File: Bender.yml
package:
  name: fire_expand

export_include_dirs:
  - .

sources:
  - fire_expand_data_pkg.sv
  - fire_expand_ctrl_pkg.sv
  - expand_ctrl.sv
  - expand_weight_rom.sv
  - mac_array.sv
  - bias_relu_quant.sv
  - wb_cfg_slave.sv
  - fire_expand_top.sv
  - target: test
    files:
      - tb_fire_expand_checker.sv
      - tb_fire_expand.sv
